// File: all.f
source/mem_map_pkg.sv
source/region_decoder.sv
source/word_ram.sv
source/access_timer.sv
source/bus_fsm.sv
source/mem_map_top.sv
tb/mem_model.sv
tb/mem_map_tb.sv

// File: run.sh
#!/bin/sh
# build and run the memory map testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns --top-module mem_map_tb \
   -f all.f -o mem_map_sim > build.log 2>&1 \
   && ./obj_dir/mem_map_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

// File: tb/mem_map_tb.sv
module mem_map_tb;
   timeunit 1ns;
   timeprecision 1ns;

   localparam int PERIOD    = 100;
   localparam int SCRATCH_N = 16;
   localparam int HW_N      = 16;
   localparam int MAIN_N    = 8;
   localparam int ACK_LIMIT = mem_map_pkg::SD_TIMEOUT + 20;
   localparam int ACCESS_COUNT = 2 * SCRATCH_N + 2 * (HW_N + 4) + 3 * MAIN_N + 9 + 7 + 3;

   localparam logic [31:0] BIOS_KUSEG = 32'h1FC0_0000;
   localparam logic [31:0] BIOS_KSEG0 = 32'h9FC0_0000;
   localparam logic [31:0] BIOS_KSEG1 = 32'hBFC0_0000;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  hang;
   mem_map_pkg::cpu_req_t req;
   logic                  ack;
   logic [31:0]           rdata;
   logic                  err;
   logic [16:0]           blk_addr;
   logic [31:0]           blk_rdata;
   logic [24:0]           sd_addr;
   logic [31:0]           sd_wdata;
   logic                  sd_rd;
   logic                  sd_wr;
   logic [31:0]           sd_rdata;
   logic                  sd_valid;
   logic                  sd_waitrequest;

   int          errors = 0;
   int          checks = 0;
   logic [31:0] rand_state = 32'h2bb9_66c2;
   logic [24:0] seen_sd_addr;
   logic [31:0] got_data;
   logic        got_err;
   logic        got_sd_rd;
   int          got_edges;
   logic [31:0] shadow [logic [31:0]];
   logic        req_up;
   logic [1:0]  req_latency;

   always #(PERIOD / 2) clk = ~clk;

   mem_map_top dut_i (
      .clk (clk), .rst (rst), .req (req), .ack (ack), .rdata (rdata), .err (err),
      .blk_addr (blk_addr), .blk_rdata (blk_rdata),
      .sd_addr (sd_addr), .sd_wdata (sd_wdata), .sd_rd (sd_rd), .sd_wr (sd_wr),
      .sd_rdata (sd_rdata), .sd_valid (sd_valid), .sd_waitrequest (sd_waitrequest)
   );

   mem_model mem_model_i (
      .clk (clk), .rst (rst), .hang (hang),
      .blk_addr (blk_addr), .blk_rdata (blk_rdata),
      .sd_addr (sd_addr), .sd_wdata (sd_wdata), .sd_rd (sd_rd), .sd_wr (sd_wr),
      .sd_rdata (sd_rdata), .sd_valid (sd_valid), .sd_waitrequest (sd_waitrequest)
   );

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   // 3 for bios, 0 for main memory, 2 for everything else.
   function automatic logic [1:0] ack_latency(input logic [31:0] a);
      if (a[31:19] == BIOS_KUSEG[31:19] || a[31:19] == BIOS_KSEG0[31:19] ||
          a[31:19] == BIOS_KSEG1[31:19]) begin
         return 2'd3;
      end
      if ((a[31:29] == 3'b000 || a[31:29] == 3'b100 || a[31:29] == 3'b101) &&
          a[28:0] < 29'h020_0000) begin
         return 2'd0;
      end
      return 2'd2;
   endfunction

   function automatic logic [31:0] bios_word(input logic [31:0] a);
      return {15'd0, a[18:2]} ^ 32'hB105_0000;
   endfunction

   function automatic logic [24:0] sd_word_addr(input logic [31:0] a);
      return {6'd0, a[20:2]} + 25'h004_0000;
   endfunction

   // **************************************************************************
   // protocol assertions
   // **************************************************************************

   assign req_up      = req.ren | req.wen;
   assign req_latency = ack_latency(req.addr);

   assert property (@(posedge clk) rst && $past(rst) |-> !ack)
      else begin
         $display("%0t: ack was high during reset", $time);
         errors++;
      end

   assert property (@(posedge clk) disable iff (rst) !(sd_rd && sd_wr))
      else begin
         $display("%0t: sdram read and write were requested together", $time);
         errors++;
      end

   // a stalled command stays put unless the access timed out.
   assert property (@(posedge clk) disable iff (rst)
      (sd_rd || sd_wr) && sd_waitrequest |=>
         ack || ($stable(sd_rd) && $stable(sd_wr) && $stable(sd_addr) && $stable(sd_wdata)))
      else begin
         $display("%0t: sdram command changed while waitrequest was high", $time);
         errors++;
      end

   // ack set on edge n after the request edge is sampled high on edge n + 1.
   assert property (@(posedge clk) disable iff (rst)
      $rose(req_up) && (req_latency == 2'd2) |-> ##3 $rose(ack))
      else begin
         $display("%0t: ack did not rise 2 edges after the request", $time);
         errors++;
      end

   assert property (@(posedge clk) disable iff (rst)
      $rose(req_up) && (req_latency == 2'd3) |-> ##4 $rose(ack))
      else begin
         $display("%0t: bios ack did not rise 3 edges after the request", $time);
         errors++;
      end

   // **************************************************************************
   // cpu tasks
   // **************************************************************************

   task automatic cpu_access(input logic [31:0] address, input logic write,
                             input logic [31:0] wdata);
      int n;
      @(posedge clk);
      req <= '{addr: address, wdata: wdata, ren: ~write, wen: write};
      seen_sd_addr = '1;
      n = 0;
      do begin
         @(negedge clk);
         n++;
         if (sd_rd || sd_wr) begin
            seen_sd_addr = sd_addr;
         end
      end while (!ack && n < ACK_LIMIT);
      got_edges = n;
      got_data  = rdata;
      got_err   = err;
      got_sd_rd = sd_rd;
      assert (ack) else begin
         $display("%0t: no ack for the access at %h", $time, address);
         errors++;
      end
      @(posedge clk);
      req <= '0;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (ack && n < ACK_LIMIT);
      assert (!ack) else begin
         $display("%0t: ack stayed high after the request at %h was dropped", $time, address);
         errors++;
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic read_expect(input logic [31:0] address, input logic [31:0] expected,
                              input logic expected_err);
      cpu_access(address, 1'b0, 32'd0);
      check_value("rdata", expected, got_data);
      check_value("err", {31'd0, expected_err}, {31'd0, got_err});
   endtask

   task automatic write_word(input logic [31:0] address, input logic [31:0] data,
                             input logic expected_err);
      cpu_access(address, 1'b1, data);
      check_value("err", {31'd0, expected_err}, {31'd0, got_err});
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   // **************************************************************************
   // tests
   // **************************************************************************

   initial begin
      int          mark;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] off;
      logic [31:0] addrs [$];
      logic [31:0] tags [$];

      rst  <= 1'b1;
      hang <= 1'b0;
      req  <= '0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      mark = errors;
      for (int i = 0; i < SCRATCH_N; i++) begin
         d = next_rand();
         a = 32'h1F80_0000 + {22'd0, d[7:0], 2'b00};
         d = next_rand();
         write_word(a, d, 1'b0);
         shadow[a] = d;
         addrs.push_back(a);
      end
      foreach (addrs[i]) begin
         read_expect(addrs[i], shadow[addrs[i]], 1'b0);
      end
      report_test("scratchpad", mark);

      // first and last words of both rams, then random registers.
      mark = errors;
      addrs.delete();
      addrs.push_back(32'h1F80_1000);
      addrs.push_back(32'h1F80_2FFC);
      addrs.push_back(32'h1F80_0000);
      addrs.push_back(32'h1F80_03FC);
      for (int i = 0; i < HW_N; i++) begin
         d = next_rand();
         addrs.push_back(32'h1F80_1000 + {19'd0, d[10:0], 2'b00});
      end
      foreach (addrs[i]) begin
         d = next_rand();
         write_word(addrs[i], d, 1'b0);
         shadow[addrs[i]] = d;
      end
      foreach (addrs[i]) begin
         read_expect(addrs[i], shadow[addrs[i]], 1'b0);
      end
      report_test("hardware registers", mark);

      mark = errors;
      for (int i = 0; i < MAIN_N; i++) begin
         d   = next_rand();
         off = {11'd0, d[20:2], 2'b00};
         d   = next_rand();
         write_word(off, d, 1'b0);
         check_value("sd_addr", {7'd0, sd_word_addr(off)}, {7'd0, seen_sd_addr});
         read_expect(32'h8000_0000 | off, d, 1'b0);
         check_value("sd_addr", {7'd0, sd_word_addr(off)}, {7'd0, seen_sd_addr});
         read_expect(32'hA000_0000 | off, d, 1'b0);
      end
      report_test("main memory", mark);

      mark = errors;
      tags.push_back(BIOS_KUSEG);
      tags.push_back(BIOS_KSEG0);
      tags.push_back(BIOS_KSEG1);
      foreach (tags[i]) begin
         d = next_rand();
         a = tags[i] | {13'd0, d[18:2], 2'b00};
         read_expect(a, bios_word(a), 1'b0);
         write_word(a, next_rand(), 1'b0);
         read_expect(a, bios_word(a), 1'b0);
      end
      report_test("bios", mark);

      mark = errors;
      d = next_rand();
      a = 32'h1F00_0000 | {16'd0, d[15:2], 2'b00};
      read_expect(a, 32'd0, 1'b0);
      write_word(a, d, 1'b0);
      read_expect(a, 32'd0, 1'b0);
      read_expect(32'h1F90_0000, 32'd0, 1'b1);
      read_expect(32'h0020_0000, 32'd0, 1'b1);
      read_expect(32'h8040_0000, 32'd0, 1'b1);
      write_word(32'h1F90_0004, d, 1'b1);
      report_test("parallel port and unmapped", mark);

      mark = errors;
      @(posedge clk);
      hang <= 1'b1;
      read_expect(32'h8000_1000, 32'd0, 1'b1);
      check_value("sd_rd", 32'd0, {31'd0, got_sd_rd});
      checks++;
      assert (got_edges >= mem_map_pkg::SD_TIMEOUT) else begin
         $display("%0t: timed-out read was acknowledged after only %0d cycles",
                  $time, got_edges);
         errors++;
      end
      @(posedge clk);
      hang <= 1'b0;
      d = next_rand();
      write_word(32'h1F80_0010, d, 1'b0);
      read_expect(32'h1F80_0010, d, 1'b0);
      report_test("sdram timeout", mark);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // every access may take the full sdram timeout plus handshake.
   initial begin
      #(PERIOD * (ACCESS_COUNT * ACK_LIMIT + 100));
      $display("watchdog expired before the tests finished");
      $display("Test failures found");
      $finish;
   end

endmodule

// File: tb/mem_model.sv
module mem_model (
   input  logic        clk,
   input  logic        rst,
   input  logic        hang,
   input  logic [16:0] blk_addr,
   output logic [31:0] blk_rdata,
   input  logic [24:0] sd_addr,
   input  logic [31:0] sd_wdata,
   input  logic        sd_rd,
   input  logic        sd_wr,
   output logic [31:0] sd_rdata,
   output logic        sd_valid,
   output logic        sd_waitrequest
);
   timeunit 1ns;
   timeprecision 1ns;

   logic [31:0] sdram [logic [24:0]];
   logic [31:0] rand_state;
   logic        pending;
   logic [2:0]  delay;
   logic [24:0] pend_addr;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         rand_state     <= 32'h2bb9_66c2;
         blk_rdata      <= '0;
         sd_rdata       <= '0;
         sd_valid       <= 1'b0;
         sd_waitrequest <= 1'b1;
         pending        <= 1'b0;
         delay          <= '0;
         pend_addr      <= '0;
      end else begin
         rand_state <= lcg_next(rand_state);
         // bios rom contents follow the word address.
         blk_rdata      <= {15'd0, blk_addr} ^ 32'hB105_0000;
         sd_waitrequest <= rand_state[16];
         sd_valid       <= 1'b0;

         // a hung read never returns valid.
         if (hang) begin
            pending <= 1'b0;
         end else if (pending) begin
            if (delay == 3'd0) begin
               pending  <= 1'b0;
               sd_valid <= 1'b1;
               if (sdram.exists(pend_addr)) begin
                  sd_rdata <= sdram[pend_addr];
               end else begin
                  sd_rdata <= {7'd0, pend_addr} ^ 32'h5DA7_0000;
               end
            end else begin
               delay <= delay - 1'b1;
            end
         end

         // command accepted on an edge with waitrequest low.
         if ((sd_rd || sd_wr) && !sd_waitrequest) begin
            if (sd_wr) begin
               sdram[sd_addr] = sd_wdata;
            end else begin
               pending   <= 1'b1;
               delay     <= rand_state[22:20];
               pend_addr <= sd_addr;
            end
         end
      end
   end

endmodule

// File: source/mem_map_top.sv
module mem_map_top (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_map_pkg::cpu_req_t req,
   output logic                  ack,
   output logic [31:0]           rdata,
   output logic                  err,

   // bios block ram.
   output logic [16:0]           blk_addr,
   input  logic [31:0]           blk_rdata,

   // sdram.
   output logic [24:0]           sd_addr,
   output logic [31:0]           sd_wdata,
   output logic                  sd_rd,
   output logic                  sd_wr,
   input  logic [31:0]           sd_rdata,
   input  logic                  sd_valid,
   input  logic                  sd_waitrequest
);

   mem_map_pkg::decode_t dec;

   logic        scratch_en;
   logic        scratch_we;
   logic [7:0]  scratch_index;
   logic [31:0] scratch_rdata;
   logic        hw_en;
   logic        hw_we;
   logic [10:0] hw_index;
   logic [31:0] hw_rdata;
   logic        timer_start;
   logic        timer_active;
   logic        expired;

   region_decoder decoder_i (
      .addr (req.addr),
      .dec  (dec)
   );

   bus_fsm fsm_i (
      .clk            (clk),
      .rst            (rst),
      .req            (req),
      .dec            (dec),
      .blk_rdata      (blk_rdata),
      .scratch_rdata  (scratch_rdata),
      .hw_rdata       (hw_rdata),
      .sd_rdata       (sd_rdata),
      .sd_valid       (sd_valid),
      .sd_waitrequest (sd_waitrequest),
      .expired        (expired),
      .ack            (ack),
      .rdata          (rdata),
      .err            (err),
      .blk_addr       (blk_addr),
      .scratch_en     (scratch_en),
      .scratch_we     (scratch_we),
      .scratch_index  (scratch_index),
      .hw_en          (hw_en),
      .hw_we          (hw_we),
      .hw_index       (hw_index),
      .sd_addr        (sd_addr),
      .sd_wdata       (sd_wdata),
      .sd_rd          (sd_rd),
      .sd_wr          (sd_wr),
      .timer_start    (timer_start),
      .timer_active   (timer_active)
   );

   access_timer timer_i (
      .clk     (clk),
      .rst     (rst),
      .start   (timer_start),
      .active  (timer_active),
      .expired (expired)
   );

   // cpu holds wdata stable until ack, so the rams take it straight from req.
   word_ram #(
      .DEPTH (mem_map_pkg::SCRATCH_WORDS)
   ) scratch_ram_i (
      .clk   (clk),
      .en    (scratch_en),
      .we    (scratch_we),
      .index (scratch_index),
      .wdata (req.wdata),
      .rdata (scratch_rdata)
   );

   word_ram #(
      .DEPTH (mem_map_pkg::HW_REG_WORDS)
   ) hw_reg_ram_i (
      .clk   (clk),
      .en    (hw_en),
      .we    (hw_we),
      .index (hw_index),
      .wdata (req.wdata),
      .rdata (hw_rdata)
   );

endmodule

// File: source/bus_fsm.sv
module bus_fsm (
   input  logic                  clk,
   input  logic                  rst,
   input  mem_map_pkg::cpu_req_t req,
   input  mem_map_pkg::decode_t  dec,
   input  logic [31:0]           blk_rdata,
   input  logic [31:0]           scratch_rdata,
   input  logic [31:0]           hw_rdata,
   input  logic [31:0]           sd_rdata,
   input  logic                  sd_valid,
   input  logic                  sd_waitrequest,
   input  logic                  expired,
   output logic                  ack,
   output logic [31:0]           rdata,
   output logic                  err,
   output logic [16:0]           blk_addr,
   output logic                  scratch_en,
   output logic                  scratch_we,
   output logic [7:0]            scratch_index,
   output logic                  hw_en,
   output logic                  hw_we,
   output logic [10:0]           hw_index,
   output logic [24:0]           sd_addr,
   output logic [31:0]           sd_wdata,
   output logic                  sd_rd,
   output logic                  sd_wr,
   output logic                  timer_start,
   output logic                  timer_active
);

   typedef enum logic [2:0] {
      idle,
      bios_wait,
      ram_access,
      sd_cmd,
      sd_read_wait,
      respond,
      hold
   } state_t;

   state_t               state;
   mem_map_pkg::region_t region_q;
   logic                 is_read;
   logic                 req_valid;
   logic [31:0]          data_q;

   assign req_valid = req.ren | req.wen;
   assign rdata     = data_q;

   // internal rams get their single access cycle in ram_access.
   assign scratch_en = (state == ram_access) && (region_q == mem_map_pkg::scratch);
   assign scratch_we = scratch_en & ~is_read;
   assign hw_en      = (state == ram_access) && (region_q == mem_map_pkg::hw_reg);
   assign hw_we      = hw_en & ~is_read;

   assign timer_start  = (state == idle) && req_valid && (dec.region == mem_map_pkg::main);
   assign timer_active = (state == sd_cmd) || (state == sd_read_wait);

   // **************************************************************************
   // control state
   // **************************************************************************

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= idle;
         ack   <= 1'b0;
         err   <= 1'b0;
         sd_rd <= 1'b0;
         sd_wr <= 1'b0;
      end else begin
         case (state)
            idle: begin
               if (req_valid) begin
                  if (dec.region == mem_map_pkg::main) begin
                     sd_rd <= req.ren;
                     sd_wr <= ~req.ren;
                     state <= sd_cmd;
                  end else begin
                     state <= ram_access;
                  end
               end
            end
            // block ram samples blk_addr here, so bios needs one more cycle.
            ram_access: begin
               state <= (region_q == mem_map_pkg::bios) ? bios_wait : respond;
            end
            bios_wait: begin
               state <= respond;
            end
            sd_cmd: begin
               if (expired) begin
                  sd_rd <= 1'b0;
                  sd_wr <= 1'b0;
                  ack   <= 1'b1;
                  err   <= 1'b1;
                  state <= hold;
               end else if (!sd_waitrequest) begin
                  // command accepted, a write is complete.
                  sd_rd <= 1'b0;
                  sd_wr <= 1'b0;
                  state <= is_read ? sd_read_wait : respond;
               end
            end
            sd_read_wait: begin
               if (expired) begin
                  ack   <= 1'b1;
                  err   <= 1'b1;
                  state <= hold;
               end else if (sd_valid) begin
                  state <= respond;
               end
            end
            respond: begin
               ack   <= 1'b1;
               err   <= (region_q == mem_map_pkg::unmapped);
               state <= hold;
            end
            hold: begin
               if (!req_valid) begin
                  ack   <= 1'b0;
                  err   <= 1'b0;
                  state <= idle;
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // **************************************************************************
   // latched request and read data
   // **************************************************************************

   always_ff @(posedge clk) begin
      case (state)
         idle: begin
            if (req_valid) begin
               region_q      <= dec.region;
               is_read       <= req.ren;
               blk_addr      <= dec.blk_addr;
               sd_addr       <= dec.sd_addr;
               sd_wdata      <= req.wdata;
               scratch_index <= dec.scratch_index;
               hw_index      <= dec.hw_index;
               data_q        <= '0;
            end
         end
         bios_wait: begin
            if (is_read) begin
               data_q <= blk_rdata;
            end
         end
         sd_read_wait: begin
            if (sd_valid && !expired) begin
               data_q <= sd_rdata;
            end
         end
         // ram output is valid one cycle after ram_access.
         respond: begin
            if (is_read && (region_q == mem_map_pkg::scratch)) begin
               data_q <= scratch_rdata;
            end else if (is_read && (region_q == mem_map_pkg::hw_reg)) begin
               data_q <= hw_rdata;
            end
         end
         default: begin
         end
      endcase
   end

endmodule

// File: source/access_timer.sv
module access_timer (
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic active,
   output logic expired
);

   logic [mem_map_pkg::SD_TIMER_W-1:0] count;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count   <= '0;
         expired <= 1'b0;
      end else if (start) begin
         count   <= '0;
         expired <= 1'b0;
      end else if (!active) begin
         // count holds until the next start.
         expired <= 1'b0;
      end else if (!expired) begin
         count <= count + 1'b1;
         // expired rises as the count reaches the limit.
         if (count == mem_map_pkg::SD_TIMER_W'(mem_map_pkg::SD_TIMEOUT - 1)) begin
            expired <= 1'b1;
         end
      end
   end

endmodule

// File: source/word_ram.sv
module word_ram #(
   parameter int DEPTH = 256
) (
   input  logic                     clk,
   input  logic                     en,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] index,
   input  logic [31:0]              wdata,
   output logic [31:0]              rdata
);

   logic [31:0] mem [DEPTH];

   // single port, read data registered on the enabling edge.
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[index] <= wdata;
         end else begin
            rdata <= mem[index];
         end
      end
   end

endmodule

// File: source/region_decoder.sv
module region_decoder (
   input  logic [31:0]          addr,
   output mem_map_pkg::decode_t dec
);

   logic in_bios;
   logic in_main;
   logic in_scratch;
   logic in_hw_reg;
   logic in_parport;

   // bios is matched on the top 13 bits only, so all 512 KB mirror.
   assign in_bios = (addr[31:19] == mem_map_pkg::BIOS_TAG_1[31:19]) ||
                    (addr[31:19] == mem_map_pkg::BIOS_TAG_2[31:19]) ||
                    (addr[31:19] == mem_map_pkg::BIOS_TAG_3[31:19]);

   assign in_main = ((addr[31:29] == mem_map_pkg::MAIN_SEG_KUSEG) ||
                     (addr[31:29] == mem_map_pkg::MAIN_SEG_KSEG0) ||
                     (addr[31:29] == mem_map_pkg::MAIN_SEG_KSEG1)) &&
                    (addr[28:0] < mem_map_pkg::MAIN_END);

   assign in_scratch = (addr >= mem_map_pkg::SCRATCH_START) &&
                       (addr <  mem_map_pkg::SCRATCH_END);
   assign in_hw_reg  = (addr >= mem_map_pkg::HW_REG_START) &&
                       (addr <  mem_map_pkg::HW_REG_END);
   assign in_parport = (addr >= mem_map_pkg::PARPORT_START) &&
                       (addr <  mem_map_pkg::PARPORT_END);

   always_comb begin
      // priority order.
      if (in_bios) begin
         dec.region = mem_map_pkg::bios;
      end else if (in_main) begin
         dec.region = mem_map_pkg::main;
      end else if (in_scratch) begin
         dec.region = mem_map_pkg::scratch;
      end else if (in_hw_reg) begin
         dec.region = mem_map_pkg::hw_reg;
      end else if (in_parport) begin
         dec.region = mem_map_pkg::parport;
      end else begin
         dec.region = mem_map_pkg::unmapped;
      end

      dec.blk_addr      = addr[18:2];
      dec.sd_addr       = {6'd0, addr[20:2]} + mem_map_pkg::MAIN_OFFSET;
      dec.scratch_index = addr[9:2];
      // word 0x400 of bits 13:2 is register 0; bit 13 only feeds the dropped carry.
      dec.hw_index      = addr[12:2] - 11'h400;
   end

endmodule

// File: source/mem_map_pkg.sv
package mem_map_pkg;

   // **************************************************************************
   // region and bus types
   // **************************************************************************

   // decoder result, in priority order.
   typedef enum logic [2:0] {
      bios,
      main,
      scratch,
      hw_reg,
      parport,
      unmapped
   } region_t;

   // one word access from the cpu.
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic        ren;
      logic        wen;
   } cpu_req_t;

   // decoded region with every per-region address already worked out.
   typedef struct packed {
      region_t     region;
      logic [16:0] blk_addr;
      logic [24:0] sd_addr;
      logic [7:0]  scratch_index;
      logic [10:0] hw_index;
   } decode_t;

   // **************************************************************************
   // address map
   // **************************************************************************

   // bios mirrors in kuseg, kseg0 and kseg1.
   localparam logic [31:0] BIOS_TAG_1 = 32'h1FC0_0000;
   localparam logic [31:0] BIOS_TAG_2 = 32'h9FC0_0000;
   localparam logic [31:0] BIOS_TAG_3 = 32'hBFC0_0000;

   localparam logic [2:0]  MAIN_SEG_KUSEG = 3'b000;
   localparam logic [2:0]  MAIN_SEG_KSEG0 = 3'b100;
   localparam logic [2:0]  MAIN_SEG_KSEG1 = 3'b101;
   localparam logic [28:0] MAIN_END       = 29'h0020_0000;   // 2 MB of main ram.
   localparam logic [24:0] MAIN_OFFSET    = 25'h004_0000;

   // range ends are exclusive.
   localparam logic [31:0] SCRATCH_START = 32'h1F80_0000;
   localparam logic [31:0] SCRATCH_END   = 32'h1F80_0400;
   localparam logic [31:0] HW_REG_START  = 32'h1F80_1000;
   localparam logic [31:0] HW_REG_END    = 32'h1F80_3000;
   localparam logic [31:0] PARPORT_START = 32'h1F00_0000;
   localparam logic [31:0] PARPORT_END   = 32'h1F01_0000;

   // sizes and limits.
   localparam int SCRATCH_WORDS = 256;
   localparam int HW_REG_WORDS  = 2048;
   localparam int SD_TIMEOUT    = 64;
   localparam int SD_TIMER_W    = $clog2(SD_TIMEOUT + 1);

endpackage
